// ==== tb.f ====
hw/snf_wdat_pkg.sv
hw/snf_burst_plan.sv
hw/snf_wdat_store.sv
hw/snf_wr_queue.sv
hw/snf_beat_counter.sv
hw/snf_wdat_top.sv
verif/tb_wdat_checker.sv
verif/tb_snf_wdat.sv

// ==== Bender.yml ====
package:
  name: snf_wdat

sources:
  - hw/snf_wdat_pkg.sv
  - hw/snf_burst_plan.sv
  - hw/snf_wdat_store.sv
  - hw/snf_wr_queue.sv
  - hw/snf_beat_counter.sv
  - hw/snf_wdat_top.sv
  - target: test
    files:
      - verif/tb_wdat_checker.sv
      - verif/tb_snf_wdat.sv

// ==== verif/tb_snf_wdat.sv ====
/*
 * testbench top for the CHI write-data buffer
 * clock, reset, request and flit stimulus, reference beat model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_snf_wdat
    import snf_wdat_pkg::*;
();

    localparam int NUM_ENTRIES = 4;

    logic clk = 1'b0;
    logic rst;
    logic alloc_valid, retire_valid, wr_start_valid, dat_valid, wready, bp_en;
    logic [1:0] alloc_idx, retire_idx, wr_start_idx, rxdat_ok_idx;
    logic [5:0] alloc_offset;
    logic [SIZE_W-1:0] alloc_size;
    logic [1:0] alloc_axlen, dat_dataid;
    logic [TXNID_W-1:0] dat_txnid;
    dat_opcode_e dat_opcode;
    logic [FLIT_BE_W-1:0] dat_be;
    logic [FLIT_DATA_W-1:0] dat_data;
    logic rxdat_ok, wlast, wvalid;
    logic [BEAT_W-1:0] wdata;
    logic [BEAT_STRB_W-1:0] wstrb;

    // expected state of each entry
    logic [LINE_W-1:0]      line_model [NUM_ENTRIES];
    logic [LINE_STRB_W-1:0] strb_model [NUM_ENTRIES];
    logic [SIZE_W-1:0]      size_model [NUM_ENTRIES];
    logic [5:0]             offset_model [NUM_ENTRIES];
    logic [1:0]             axlen_model [NUM_ENTRIES];
    logic [1:0]             recv_model [NUM_ENTRIES];
    logic [31:0] seed = 32'h3501_79e3;
    logic [31:0] bp_seed = 32'h3501_79e3;
    logic [31:0] word;

    always #20 clk = ~clk;

    snf_wdat_top #(.NUM_ENTRIES(NUM_ENTRIES)) dut_i (.*);

    tb_wdat_checker chk_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // beat k of an entry's burst as {wlast, wstrb, wdata}
    function automatic logic [BEAT_W+BEAT_STRB_W:0] ref_beat(input int idx, input int k);
        int beats;
        int b;
        beats = axlen_model[idx] + 1;
        b = (offset_model[idx][5:4] / beats) * beats + k;
        return {k == beats - 1, strb_model[idx][b*BEAT_STRB_W +: BEAT_STRB_W],
                line_model[idx][b*BEAT_W +: BEAT_W]};
    endfunction

    // wready pattern for the back-pressure test
    always @(posedge clk) begin
        #2;
        if (bp_en) begin
            bp_seed = lcg_next(bp_seed);
            wready = bp_seed[20];
        end else begin
            wready = 1'b1;
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic alloc_entry(input int idx, input logic [5:0] offset,
                               input logic [SIZE_W-1:0] size, input logic [1:0] axlen);
        step();
        alloc_valid = 1'b1;
        alloc_idx = 2'(idx);
        alloc_offset = offset;
        alloc_size = size;
        alloc_axlen = axlen;
        offset_model[idx] = offset;
        size_model[idx] = size;
        axlen_model[idx] = axlen;
        step();
        alloc_valid = 1'b0;
    endtask

    task automatic retire_entry(input int idx);
        step();
        retire_valid = 1'b1;
        retire_idx = 2'(idx);
        line_model[idx] = '0;
        strb_model[idx] = '0;
        recv_model[idx] = '0;
        step();
        retire_valid = 1'b0;
    endtask

    task automatic send_flit(input int idx, input logic [1:0] dataid, input dat_opcode_e op,
                             input logic [FLIT_BE_W-1:0] be);
        logic [FLIT_DATA_W-1:0] d;
        int half;
        half = dataid[1];
        for (int i = 0; i < 8; i++) begin
            seed = lcg_next(seed);
            d[32*i +: 32] = seed;
        end
        step();
        dat_valid = 1'b1;
        dat_txnid = {seed[21:12], 2'(idx)};
        dat_opcode = op;
        dat_dataid = dataid;
        dat_be = be;
        dat_data = d;
        // cancel counts as received but carries nothing
        if (op != DAT_WRITEDATACANCEL) begin
            line_model[idx][half*FLIT_DATA_W +: FLIT_DATA_W] =
                line_model[idx][half*FLIT_DATA_W +: FLIT_DATA_W] | d;
            strb_model[idx][half*FLIT_BE_W +: FLIT_BE_W] =
                strb_model[idx][half*FLIT_BE_W +: FLIT_BE_W] | be;
        end
        recv_model[idx][half] = 1'b1;
        if (size_model[idx] != SIZE_LINE || recv_model[idx] == 2'b11) begin
            chk_i.expect_ok(2'(idx));
            recv_model[idx] = 2'b00;
        end
        step();
        dat_valid = 1'b0;
    endtask

    task automatic start_drain(input int idx);
        for (int k = 0; k <= axlen_model[idx]; k++) begin
            chk_i.expect_beat(ref_beat(idx, k));
        end
        step();
        wr_start_valid = 1'b1;
        wr_start_idx = 2'(idx);
        step();
        wr_start_valid = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (chk_i.outstanding != 0 && cycles < 500) begin
            step();
            cycles++;
        end
        if (chk_i.outstanding != 0) begin
            $display("timeout in test %s with %0d beats or completions still missing",
                     chk_i.test_name, chk_i.outstanding);
            $display("Finished with errors");
            $finish;
        end else begin
            repeat (4) step();
            chk_i.end_test();
        end
    endtask

    initial begin
        rst = 1'b1;
        alloc_valid = 1'b0;
        alloc_idx = '0;
        alloc_offset = '0;
        alloc_size = '0;
        alloc_axlen = '0;
        retire_valid = 1'b0;
        retire_idx = '0;
        wr_start_valid = 1'b0;
        wr_start_idx = '0;
        dat_valid = 1'b0;
        dat_txnid = '0;
        dat_opcode = DAT_NONCOPYBACK_WRDATA;
        dat_dataid = '0;
        dat_be = '0;
        dat_data = '0;
        wready = 1'b1;
        bp_en = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            line_model[i] = '0;
            strb_model[i] = '0;
            recv_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        step();
        chk_i.end_test();

        chk_i.start_test("full_line");
        alloc_entry(0, 6'h00, SIZE_LINE, 2'd3);
        send_flit(0, 2'd0, DAT_NONCOPYBACK_WRDATA, '1);
        send_flit(0, 2'd2, DAT_COPYBACK_WRDATA, '1);
        start_drain(0);
        wait_done();

        chk_i.start_test("partial");
        alloc_entry(1, 6'h14, 3'd3, 2'd0);
        send_flit(1, 2'd0, DAT_NONCOPYBACK_WRDATA, 32'h00ff_0000);
        start_drain(1);
        wait_done();

        chk_i.start_test("windowed");
        alloc_entry(2, 6'h38, 3'd5, 2'd1);
        alloc_entry(3, 6'h10, 3'd5, 2'd1);
        send_flit(2, 2'd2, DAT_NONCOPYBACK_WRDATA, '1);
        send_flit(3, 2'd0, DAT_NONCOPYBACK_WRDATA, '1);
        start_drain(2);
        start_drain(3);
        wait_done();

        chk_i.start_test("cancel");
        retire_entry(1);
        alloc_entry(1, 6'h00, SIZE_LINE, 2'd3);
        send_flit(1, 2'd0, DAT_COPYBACK_WRDATA, '1);
        send_flit(1, 2'd2, DAT_WRITEDATACANCEL, '1);
        start_drain(1);
        wait_done();

        chk_i.start_test("backpressure");
        retire_entry(0);
        retire_entry(2);
        retire_entry(3);
        alloc_entry(0, 6'h00, SIZE_LINE, 2'd3);
        alloc_entry(2, 6'h20, SIZE_LINE, 2'd1);
        alloc_entry(3, 6'h30, 3'd4, 2'd0);
        send_flit(0, 2'd0, DAT_NONCOPYBACK_WRDATA, '1);
        send_flit(2, 2'd0, DAT_NONCOPYBACK_WRDATA, 32'h0f0f_f0f0);
        send_flit(0, 2'd2, DAT_NONCOPYBACK_WRDATA, '1);
        send_flit(2, 2'd2, DAT_COPYBACK_WRDATA, 32'hffff_00ff);
        send_flit(3, 2'd2, DAT_NONCOPYBACK_WRDATA, 32'hffff_0000);
        bp_en = 1'b1;
        start_drain(2);
        start_drain(0);
        start_drain(3);
        wait_done();
        bp_en = 1'b0;

        chk_i.start_test("retire_reuse");
        retire_entry(0);
        alloc_entry(0, 6'h00, SIZE_LINE, 2'd3);
        seed = lcg_next(seed);
        word = seed;
        send_flit(0, 2'd0, DAT_NONCOPYBACK_WRDATA, word);
        send_flit(0, 2'd2, DAT_NONCOPYBACK_WRDATA, ~word);
        start_drain(0);
        wait_done();

        $display("%0d tests run, %0d failed, %0d errors",
                 chk_i.tests, chk_i.tests_failed, chk_i.errors);
        if (chk_i.errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_wdat_checker.sv ====
/*
 * W channel and completion monitor
 * compares observed beats and rxdat_ok against expected queues
 */
`timescale 1ns/100ps
`default_nettype none

module tb_wdat_checker
    import snf_wdat_pkg::*;
(
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic                   rxdat_ok,
    input wire logic [1:0]             rxdat_ok_idx,
    input wire logic [BEAT_W-1:0]      wdata,
    input wire logic [BEAT_STRB_W-1:0] wstrb,
    input wire logic                   wlast,
    input wire logic                   wvalid,
    input wire logic                   wready
);

    // {wlast, wstrb, wdata} per beat
    logic [BEAT_W+BEAT_STRB_W:0] exp_beats [$];
    logic [1:0]                  exp_ok [$];
    int                          exp_ok_cycle [$];
    logic [BEAT_W+BEAT_STRB_W:0] beat;
    logic [1:0]                  ok_idx;
    int                          ok_cycle;
    string test_name = "reset";
    int    cycle_count = 0;
    int    outstanding = 0;
    int    test_errors = 0;
    int    errors = 0;
    int    tests = 0;
    int    tests_failed = 0;

    task automatic check_value(input string what, input logic [BEAT_W-1:0] exp,
                               input logic [BEAT_W-1:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s expected %0h actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic expect_beat(input logic [BEAT_W+BEAT_STRB_W:0] b);
        exp_beats.push_back(b);
        outstanding++;
    endtask

    task automatic expect_ok(input logic [1:0] idx);
        exp_ok.push_back(idx);
        // flit taken on the next edge, pulse in the cycle after
        exp_ok_cycle.push_back(cycle_count + 1);
        outstanding++;
    endtask

    always @(posedge clk) begin
        cycle_count++;
    end

    // inputs change just after the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst && (wvalid || wlast || rxdat_ok)) begin
            report_failure("wvalid, wlast or rxdat_ok is high during reset");
        end
        if (!rst && wvalid && wready) begin
            if (exp_beats.size() == 0) begin
                report_failure("a W beat was accepted with none expected");
            end else begin
                beat = exp_beats.pop_front();
                outstanding--;
                check_value("wdata", beat[BEAT_W-1:0], wdata);
                check_value("wstrb", BEAT_W'(beat[BEAT_W +: BEAT_STRB_W]), BEAT_W'(wstrb));
                check_value("wlast", BEAT_W'(beat[BEAT_W+BEAT_STRB_W]), BEAT_W'(wlast));
            end
        end
        if (!rst && rxdat_ok) begin
            if (exp_ok.size() == 0) begin
                report_failure("rxdat_ok pulsed with no completion expected");
            end else begin
                ok_idx = exp_ok.pop_front();
                ok_cycle = exp_ok_cycle.pop_front();
                outstanding--;
                check_value("rxdat_ok_idx", BEAT_W'(ok_idx), BEAT_W'(rxdat_ok_idx));
                check_value("rxdat_ok_cycle", BEAT_W'(ok_cycle), BEAT_W'(cycle_count));
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/snf_wdat_top.sv ====
/*
 * CHI write-data buffer in front of a 128-bit AXI W channel
 * burst plan, line store, drain queue and beat counter
 */
`timescale 1ns/100ps
`default_nettype none

module snf_wdat_top
    import snf_wdat_pkg::*;
#(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   alloc_valid,
    input  wire logic [IDX_W-1:0]       alloc_idx,
    input  wire logic [5:0]             alloc_offset,
    input  wire logic [SIZE_W-1:0]      alloc_size,
    input  wire logic [BANK_IDX_W-1:0]  alloc_axlen,
    input  wire logic                   retire_valid,
    input  wire logic [IDX_W-1:0]       retire_idx,
    input  wire logic                   wr_start_valid,
    input  wire logic [IDX_W-1:0]       wr_start_idx,
    input  wire logic                   dat_valid,
    input  wire logic [TXNID_W-1:0]     dat_txnid,
    input  wire dat_opcode_e            dat_opcode,
    input  wire logic [DATAID_W-1:0]    dat_dataid,
    input  wire logic [FLIT_BE_W-1:0]   dat_be,
    input  wire logic [FLIT_DATA_W-1:0] dat_data,
    output logic                        rxdat_ok,
    output logic      [IDX_W-1:0]       rxdat_ok_idx,
    output logic      [BEAT_W-1:0]      wdata,
    output logic      [BEAT_STRB_W-1:0] wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    input  wire logic                   wready
);

    logic [IDX_W-1:0]      dat_idx;
    logic [SIZE_W-1:0]     dat_size;
    logic                  head_valid;
    logic [IDX_W-1:0]      head_idx;
    logic [BANK_IDX_W-1:0] first_bank;
    logic [BANK_IDX_W-1:0] last_bank;
    logic [BANK_IDX_W-1:0] bank;
    logic                  beat_last;
    logic                  beat_accept;
    logic                  pop;

    // entry is the low txnid bits
    assign dat_idx     = dat_txnid[IDX_W-1:0];
    assign wvalid      = head_valid;
    assign wlast       = beat_last;
    assign beat_accept = wvalid & wready;
    assign pop         = wvalid & wready & wlast;

    snf_burst_plan #(.NUM_ENTRIES(NUM_ENTRIES)) plan_i (
        .clk, .rst, .alloc_valid, .alloc_idx, .alloc_offset, .alloc_size, .alloc_axlen,
        .retire_valid, .retire_idx, .dat_idx, .dat_size, .head_idx, .first_bank, .last_bank
    );

    snf_wdat_store #(.NUM_ENTRIES(NUM_ENTRIES)) store_i (
        .clk, .rst, .dat_valid, .dat_idx, .dat_opcode, .dat_dataid, .dat_be, .dat_data,
        .dat_size, .retire_valid, .retire_idx, .head_idx, .bank,
        .beat_data(wdata), .beat_strb(wstrb), .rxdat_ok, .rxdat_ok_idx
    );

    snf_wr_queue #(.NUM_ENTRIES(NUM_ENTRIES)) queue_i (
        .clk, .rst, .wr_start_valid, .wr_start_idx, .pop, .head_valid, .head_idx
    );

    snf_beat_counter counter_i (
        .clk, .rst, .beat_accept, .first_bank, .last_bank, .bank, .last(beat_last)
    );

endmodule

`default_nettype wire

// ==== hw/snf_beat_counter.sv ====
/*
 * beat offset within the head burst, bank number and last flag
 */
`timescale 1ns/100ps
`default_nettype none

module snf_beat_counter
    import snf_wdat_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  beat_accept,
    input  wire logic [BANK_IDX_W-1:0] first_bank,
    input  wire logic [BANK_IDX_W-1:0] last_bank,
    output logic      [BANK_IDX_W-1:0] bank,
    output logic                       last
);

    logic [BANK_IDX_W-1:0] offset_q;

    assign bank = first_bank + offset_q;
    assign last = (bank == last_bank);

    // holds under back-pressure, restarts after the last beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset_q <= '0;
        end else if (beat_accept) begin
            offset_q <= last ? '0 : offset_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snf_wr_queue.sv ====
/*
 * in-order ring of entries waiting for the W channel
 */
`timescale 1ns/100ps
`default_nettype none

module snf_wr_queue #(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wr_start_valid,
    input  wire logic [IDX_W-1:0] wr_start_idx,
    input  wire logic             pop,
    output logic                  head_valid,
    output logic      [IDX_W-1:0] head_idx
);

    logic [NUM_ENTRIES-1:0] slot_valid;
    logic [IDX_W-1:0]       slot_idx [NUM_ENTRIES];
    logic [IDX_W-1:0]       wr_ptr;
    logic [IDX_W-1:0]       rd_ptr;

    function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(NUM_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            slot_valid <= '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                slot_idx[i] <= '0;
            end
        end else begin
            if (wr_start_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (wr_start_valid && wr_ptr == IDX_W'(i)) begin
                    slot_valid[i] <= 1'b1;
                    slot_idx[i]   <= wr_start_idx;
                end else if (pop && rd_ptr == IDX_W'(i)) begin
                    slot_valid[i] <= 1'b0;
                    slot_idx[i]   <= '0;
                end
            end
        end
    end

    assign head_valid = slot_valid[rd_ptr];
    assign head_idx   = slot_idx[rd_ptr];

endmodule

`default_nettype wire

// ==== hw/snf_wdat_store.sv ====
/*
 * per-entry line data and strobes, flit merge and receive tracking
 * completion pulse and W channel bank select
 */
`timescale 1ns/100ps
`default_nettype none

module snf_wdat_store
    import snf_wdat_pkg::*;
#(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   dat_valid,
    input  wire logic [IDX_W-1:0]       dat_idx,
    input  wire dat_opcode_e            dat_opcode,
    input  wire logic [DATAID_W-1:0]    dat_dataid,
    input  wire logic [FLIT_BE_W-1:0]   dat_be,
    input  wire logic [FLIT_DATA_W-1:0] dat_data,
    input  wire logic [SIZE_W-1:0]      dat_size,
    input  wire logic                   retire_valid,
    input  wire logic [IDX_W-1:0]       retire_idx,
    input  wire logic [IDX_W-1:0]       head_idx,
    input  wire logic [BANK_IDX_W-1:0]  bank,
    output logic      [BEAT_W-1:0]      beat_data,
    output logic      [BEAT_STRB_W-1:0] beat_strb,
    output logic                        rxdat_ok,
    output logic      [IDX_W-1:0]       rxdat_ok_idx
);

    logic [LINE_W-1:0]      line_data [NUM_ENTRIES];
    logic [LINE_STRB_W-1:0] line_strb [NUM_ENTRIES];
    logic [1:0]             recv_q    [NUM_ENTRIES];
    logic                   ok_q;
    logic [IDX_W-1:0]       last_idx_q;

    logic                   flit_lo;
    logic                   flit_hi;
    logic                   merge_en;
    logic [LINE_W-1:0]      merge_data;
    logic [LINE_STRB_W-1:0] merge_strb;
    logic [1:0]             recv_next;
    logic                   flit_done;

    assign flit_lo  = (dat_dataid == 2'b00);
    assign flit_hi  = (dat_dataid == 2'b10);
    // cancel still counts as received
    assign merge_en = dat_valid && (dat_opcode != DAT_WRITEDATACANCEL) && (flit_lo || flit_hi);

    assign merge_data = flit_hi ? {dat_data, {FLIT_DATA_W{1'b0}}} : {{FLIT_DATA_W{1'b0}}, dat_data};
    assign merge_strb = flit_hi ? {dat_be, {FLIT_BE_W{1'b0}}} : {{FLIT_BE_W{1'b0}}, dat_be};

    assign recv_next = recv_q[dat_idx] | (flit_hi ? 2'b10 : 2'b01);
    assign flit_done = (dat_size == SIZE_LINE) ? (recv_next == 2'b11) : 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                line_data[i] <= '0;
                line_strb[i] <= '0;
                recv_q[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (merge_en && dat_idx == IDX_W'(i)) begin
                    line_data[i] <= line_data[i] | merge_data;
                    line_strb[i] <= line_strb[i] | merge_strb;
                end else if (retire_valid && retire_idx == IDX_W'(i)) begin
                    line_data[i] <= '0;
                    line_strb[i] <= '0;
                end
                // tracking restarts once the entry completes
                if (dat_valid && dat_idx == IDX_W'(i)) begin
                    recv_q[i] <= flit_done ? 2'b00 : recv_next;
                end else if (retire_valid && retire_idx == IDX_W'(i)) begin
                    recv_q[i] <= 2'b00;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ok_q       <= 1'b0;
            last_idx_q <= '0;
        end else begin
            ok_q <= dat_valid && flit_done;
            if (dat_valid) begin
                last_idx_q <= dat_idx;
            end
        end
    end

    assign rxdat_ok     = ok_q;
    assign rxdat_ok_idx = last_idx_q;

    assign beat_data = line_data[head_idx][bank*BEAT_W +: BEAT_W];
    assign beat_strb = line_strb[head_idx][bank*BEAT_STRB_W +: BEAT_STRB_W];

endmodule

`default_nettype wire

// ==== hw/snf_burst_plan.sv ====
/*
 * per-entry request size and burst bank window
 * window computed at allocation, looked up for flit and queue head
 */
`timescale 1ns/100ps
`default_nettype none

module snf_burst_plan
    import snf_wdat_pkg::*;
#(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  alloc_valid,
    input  wire logic [IDX_W-1:0]      alloc_idx,
    input  wire logic [5:0]            alloc_offset,
    input  wire logic [SIZE_W-1:0]     alloc_size,
    input  wire logic [BANK_IDX_W-1:0] alloc_axlen,
    input  wire logic                  retire_valid,
    input  wire logic [IDX_W-1:0]      retire_idx,
    input  wire logic [IDX_W-1:0]      dat_idx,
    output logic      [SIZE_W-1:0]     dat_size,
    input  wire logic [IDX_W-1:0]      head_idx,
    output logic      [BANK_IDX_W-1:0] first_bank,
    output logic      [BANK_IDX_W-1:0] last_bank
);

    logic [SIZE_W-1:0]     size_q  [NUM_ENTRIES];
    logic [BANK_IDX_W-1:0] first_q [NUM_ENTRIES];
    logic [BANK_IDX_W-1:0] last_q  [NUM_ENTRIES];
    logic [BANK_IDX_W-1:0] alloc_bank;
    logic [BANK_IDX_W-1:0] alloc_first;
    logic [BANK_IDX_W-1:0] alloc_last;

    assign alloc_bank  = alloc_offset[5:4];
    // bank aligned down to the burst length
    assign alloc_first = alloc_bank & ~alloc_axlen;
    assign alloc_last  = alloc_first + alloc_axlen;

    // an idle entry spans the whole line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                size_q[i]  <= '0;
                first_q[i] <= '0;
                last_q[i]  <= BANK_IDX_W'(BANKS - 1);
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (alloc_valid && alloc_idx == IDX_W'(i)) begin
                    size_q[i]  <= alloc_size;
                    first_q[i] <= alloc_first;
                    last_q[i]  <= alloc_last;
                end else if (retire_valid && retire_idx == IDX_W'(i)) begin
                    size_q[i]  <= '0;
                    first_q[i] <= '0;
                    last_q[i]  <= BANK_IDX_W'(BANKS - 1);
                end
            end
        end
    end

    assign dat_size   = size_q[dat_idx];
    assign first_bank = first_q[head_idx];
    assign last_bank  = last_q[head_idx];

endmodule

`default_nettype wire

// ==== hw/snf_wdat_pkg.sv ====
/*
 * widths and derived sizes for the write-data buffer
 * CHI data opcode encodings
 */
`default_nettype none

package snf_wdat_pkg;

    // CHI data flit
    localparam int FLIT_DATA_W = 256;
    localparam int FLIT_BE_W   = 32;
    localparam int DATAID_W    = 2;
    localparam int TXNID_W     = 12;

    // AXI W channel beat
    localparam int BEAT_W      = 128;
    localparam int BEAT_STRB_W = 16;

    // one 64-byte line per entry
    localparam int LINE_W      = 2 * FLIT_DATA_W;
    localparam int LINE_STRB_W = 2 * FLIT_BE_W;
    localparam int BANKS       = LINE_W / BEAT_W;
    localparam int BANK_IDX_W  = $clog2(BANKS);

    localparam int SIZE_W = 3;
    localparam logic [SIZE_W-1:0] SIZE_LINE = 3'd6;

    typedef enum logic [3:0] {
        DAT_COPYBACK_WRDATA    = 4'h2,
        DAT_NONCOPYBACK_WRDATA = 4'h3,
        DAT_WRITEDATACANCEL    = 4'h7
    } dat_opcode_e;

endpackage

`default_nettype wire
